// File: build.f
+incdir+include
src/spm_pkg.sv
src/sp_sram.sv
src/ecc_encode.sv
src/ecc_decode.sv
src/err_log.sv
src/spm_ctrl.sv
src/spm_top.sv
testbench/spm_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module spm_tb \
  -Mdir obj_dir -o spm_sim -f build.f
./obj_dir/spm_sim 2>&1 | tee sim.log
if grep -qx "Test passed" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: testbench/spm_tb.sv
`include "spm_cfg.svh"

module spm_tb;

  localparam int lat_full    = 1;                   // full write
  localparam int lat_read    = `SPM_OUT_REGS + 2;   // L+1
  localparam int lat_partial = `SPM_OUT_REGS + 3;   // L+2
  localparam int ack_timeout = 20;
  localparam int err_none    = 0;
  localparam int err_single  = 1;
  localparam int err_double  = 2;

  logic                   clk_i = 1'b0;
  logic                   rst_i;
  logic                   req_i;
  logic                   we_i;
  logic [`SPM_ADDR_W-1:0] addr_i;
  logic [`SPM_DATA_W-1:0] wdata_i;
  logic [`SPM_BE_W-1:0]   be_i;
  logic                   inject_s_i;
  logic                   inject_d_i;
  logic                   ack_o;
  logic [`SPM_DATA_W-1:0] rdata_o;
  logic                   err_corr_o;
  logic                   err_uncorr_o;
  logic [`SPM_CNT_W-1:0]  corr_count_o;
  logic [`SPM_ADDR_W-1:0] last_err_addr_o;

  // shadow memory, data and error state per word
  logic [`SPM_DATA_W-1:0] mdl_data [`SPM_WORDS];
  int                     mdl_err  [`SPM_WORDS];

  // expectations staged with req_i, taken over when the strobe is sampled
  logic [7:0]             next_lat    = '0;
  logic                   next_corr   = 1'b0;
  logic                   next_uncorr = 1'b0;
  logic                   next_chk    = 1'b0;  // compare rdata_o
  logic [`SPM_DATA_W-1:0] next_data   = '0;
  logic [`SPM_ADDR_W-1:0] next_addr   = '0;
  logic [7:0]             pend_lat    = '0;
  logic                   pend_corr   = 1'b0;
  logic                   pend_uncorr = 1'b0;
  logic                   pend_chk    = 1'b0;
  logic [`SPM_DATA_W-1:0] pend_data   = '0;
  logic [`SPM_ADDR_W-1:0] pend_addr   = '0;

  logic                   busy_q    = 1'b0; // request outstanding
  logic [7:0]             cycles_q  = '0;   // edges since the sampled strobe
  logic [`SPM_CNT_W-1:0]  exp_count = '0;
  logic [`SPM_ADDR_W-1:0] exp_last  = '0;

  int unsigned seed_val;
  int          errors     = 0;
  int          test_base  = 0;
  int          tests_done = 0;
  int          req_count  = 0;

  spm_top dut_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_i           (req_i),
    .we_i            (we_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .be_i            (be_i),
    .inject_s_i      (inject_s_i),
    .inject_d_i      (inject_d_i),
    .ack_o           (ack_o),
    .rdata_o         (rdata_o),
    .err_corr_o      (err_corr_o),
    .err_uncorr_o    (err_uncorr_o),
    .corr_count_o    (corr_count_o),
    .last_err_addr_o (last_err_addr_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
    errors++;
  endtask

  task automatic note_error(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
  endtask

  // pending expectations and logger model, both follow the DUT strobes
  always @(posedge clk_i) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      cycles_q  <= '0;
      exp_count <= '0;
      exp_last  <= '0;
    end else begin
      if (ack_o && pend_corr) exp_count <= exp_count + 1'b1; // logger lags ack by one
      if (ack_o && (pend_corr || pend_uncorr)) exp_last <= pend_addr;
      if (req_i) begin
        busy_q      <= 1'b1;
        cycles_q    <= '0;
        pend_lat    <= next_lat;
        pend_corr   <= next_corr;
        pend_uncorr <= next_uncorr;
        pend_chk    <= next_chk;
        pend_data   <= next_data;
        pend_addr   <= next_addr;
      end else begin
        if (ack_o) busy_q <= 1'b0;
        if (cycles_q != '1) cycles_q <= cycles_q + 1'b1;
      end
    end
  end

  a_ack_req: assert property (@(posedge clk_i) disable iff (rst_i) ack_o |-> busy_q)
    else note_error("ack_o seen with no request outstanding");
  a_chain_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    (req_i && busy_q) |-> ack_o)
    else note_error("next request sent but ack_o of the previous one missing");
  a_flags_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    !ack_o |-> !(err_corr_o || err_uncorr_o))
    else note_error("error flag high outside the ack cycle");
  a_overdue: assert property (@(posedge clk_i) disable iff (rst_i)
    busy_q |-> (cycles_q <= pend_lat))
    else note_error("ack_o missing for an outstanding request");
  a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |-> (cycles_q == pend_lat))
    else mismatch("ack latency", 32'($sampled(cycles_q)), 32'($sampled(pend_lat)));
  a_corr: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |-> (err_corr_o == pend_corr))
    else mismatch("err_corr_o", 32'($sampled(err_corr_o)), 32'($sampled(pend_corr)));
  a_uncorr: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |-> (err_uncorr_o == pend_uncorr))
    else mismatch("err_uncorr_o", 32'($sampled(err_uncorr_o)), 32'($sampled(pend_uncorr)));
  a_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_o && pend_chk) |-> (rdata_o == pend_data))
    else mismatch("rdata_o", $sampled(rdata_o), $sampled(pend_data));
  a_count: assert property (@(posedge clk_i) disable iff (rst_i)
    corr_count_o == exp_count)
    else mismatch("corr_count_o", 32'($sampled(corr_count_o)), 32'($sampled(exp_count)));
  a_last: assert property (@(posedge clk_i) disable iff (rst_i)
    last_err_addr_o == exp_last)
    else mismatch("last_err_addr_o", 32'($sampled(last_err_addr_o)), 32'($sampled(exp_last)));

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'ha5, a + 8'h3c}; // every address bit shows up
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return m;
  endfunction

  // returns on the ack edge, or one edge earlier when chaining the next strobe
  task automatic wait_ack(input int lat, input bit chain);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && (n < ack_timeout)) begin
      @(posedge clk_i);
      n++;
      if (chain && (n == lat)) seen = 1'b1;
      else if (ack_o) seen = 1'b1;
    end
    if (!seen) begin
      $display("no ack_o within %0d cycles of the request at %0t", ack_timeout, $time);
      $display("Test failed");
      $finish;
    end
  endtask

  // caller sits on a rising edge
  task automatic issue(input bit we, input logic [7:0] addr, input logic [31:0] data,
                       input logic [3:0] be, input bit inj_s, input bit inj_d, input bit chain);
    int          lat;
    int          st;
    bit          corr;
    bit          unc;
    bit          chk;
    logic [31:0] want;
    st   = mdl_err[addr];
    corr = 1'b0;
    unc  = 1'b0;
    chk  = 1'b0;
    want = mdl_data[addr];
    if (!we) begin
      lat  = lat_read;
      corr = (st == err_single);
      unc  = (st == err_double);
      chk  = (st != err_double);
    end else if (be == 4'hf) begin
      lat            = lat_full;
      mdl_data[addr] = data;
      mdl_err[addr]  = inj_d ? err_double : (inj_s ? err_single : err_none);
    end else if (st == err_double) begin
      lat = lat_read; // aborted, word left alone
      unc = 1'b1;
    end else begin
      lat            = lat_partial;
      corr           = (st == err_single);
      mdl_data[addr] = merge_bytes(mdl_data[addr], data, be);
      mdl_err[addr]  = inj_d ? err_double : (inj_s ? err_single : err_none);
    end
    req_i       <= 1'b1;
    we_i        <= we;
    addr_i      <= addr;
    wdata_i     <= data;
    be_i        <= be;
    inject_s_i  <= inj_s;
    inject_d_i  <= inj_d;
    next_lat    <= 8'(lat);
    next_corr   <= corr;
    next_uncorr <= unc;
    next_chk    <= chk;
    next_data   <= want;
    next_addr   <= addr;
    req_count++;
    @(posedge clk_i);
    req_i      <= 1'b0;
    inject_s_i <= 1'b0;
    inject_d_i <= 1'b0;
    wait_ack(lat, chain);
  endtask

  task automatic end_test(input string name);
    tests_done++;
    $display("[%0d] %s: %0d errors", tests_done, name, errors - test_base);
    test_base = errors;
  endtask

  initial begin
    logic [7:0]  ad;
    logic [31:0] d;
    logic [3:0]  be;
    bit          wr;
    bit          inj_s;
    bit          inj_d;
    seed_val   = $urandom(32'h19f44b6c);
    rst_i      = 1'b1;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    be_i       = '0;
    inject_s_i = 1'b0;
    inject_d_i = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    // quiet bus first, then one of each request kind
    repeat (8) @(posedge clk_i);
    issue(1'b1, 8'd0, $urandom, 4'hf, 1'b0, 1'b0, 1'b0);
    issue(1'b0, 8'd0, '0, 4'h0, 1'b0, 1'b0, 1'b0);
    issue(1'b1, 8'd0, $urandom, 4'b0101, 1'b0, 1'b0, 1'b0);
    issue(1'b1, 8'd1, $urandom, 4'hf, 1'b0, 1'b1, 1'b0);
    issue(1'b1, 8'd1, $urandom, 4'b0011, 1'b0, 1'b0, 1'b0); // aborted rmw
    end_test("reset and latency");

    for (int a = 0; a < `SPM_WORDS; a++) begin
      issue(1'b1, 8'(a), fill_word(8'(a)), 4'hf, 1'b0, 1'b0, a[0]);
    end
    for (int a = 0; a < `SPM_WORDS; a++) begin
      issue(1'b0, 8'(a), '0, 4'h0, 1'b0, 1'b0, a[0]);
    end
    for (int i = 0; i < 40; i++) begin
      ad = 8'($urandom);
      issue(1'b1, ad, $urandom, 4'hf, 1'b0, 1'b0, 1'b1);
      issue(1'b0, ad, '0, 4'h0, 1'b0, 1'b0, 1'b0);
    end
    end_test("full write and read");

    for (int i = 0; i < 40; i++) begin
      ad = 8'($urandom);
      be = 4'($urandom % 15); // never all four
      issue(1'b1, ad, $urandom, be, 1'b0, 1'b0, 1'b0);
      issue(1'b0, ad, '0, 4'h0, 1'b0, 1'b0, 1'b0);
    end
    end_test("partial write");

    for (int i = 0; i < 5; i++) begin
      ad = 8'($urandom);
      issue(1'b1, ad, $urandom, 4'hf, 1'b1, 1'b0, 1'b0);
      issue(1'b0, ad, '0, 4'h0, 1'b0, 1'b0, 1'b0);
      issue(1'b1, ad, $urandom, 4'b1000, 1'b0, 1'b0, 1'b0); // corrects old word
      issue(1'b0, ad, '0, 4'h0, 1'b0, 1'b0, 1'b0);
    end
    end_test("single-bit injection");

    for (int i = 0; i < 5; i++) begin
      ad = 8'($urandom);
      issue(1'b1, ad, $urandom, 4'hf, 1'b0, 1'b1, 1'b0);
      issue(1'b0, ad, '0, 4'h0, 1'b0, 1'b0, 1'b0);
      issue(1'b1, ad, $urandom, 4'b0110, 1'b0, 1'b0, 1'b0);
      issue(1'b0, ad, '0, 4'h0, 1'b0, 1'b0, 1'b0);
    end
    end_test("double-bit injection");

    for (int i = 0; i < 200; i++) begin
      ad    = 8'($urandom);
      d     = $urandom;
      wr    = $urandom % 2;
      be    = ($urandom % 2) ? 4'hf : 4'($urandom);
      inj_s = ($urandom % 16) == 0;
      inj_d = ($urandom % 16) == 0;
      issue(wr, ad, d, be, inj_s, inj_d, (i != 199) && ($urandom % 2));
    end
    end_test("mixed traffic");

    repeat (4) @(posedge clk_i); // let the last logger update be checked
    $display("%0d tests, %0d requests, %0d errors", tests_done, req_count, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src/spm_top.sv
`include "spm_cfg.svh"

module spm_top import spm_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`SPM_ADDR_W-1:0] addr_i,
  input  logic [`SPM_DATA_W-1:0] wdata_i,
  input  logic [`SPM_BE_W-1:0]   be_i,
  input  logic                   inject_s_i,
  input  logic                   inject_d_i,
  output logic                   ack_o,
  output logic [`SPM_DATA_W-1:0] rdata_o,
  output logic                   err_corr_o,
  output logic                   err_uncorr_o,
  output logic [`SPM_CNT_W-1:0]  corr_count_o,
  output logic [`SPM_ADDR_W-1:0] last_err_addr_o
);

  logic                   mem_req;
  logic                   mem_we;
  logic [`SPM_ADDR_W-1:0] mem_addr;
  logic                   mem_inject_s;
  logic                   mem_inject_d;
  logic [`SPM_DATA_W-1:0] enc_data;   // merged or full word to encode
  codeword_t              enc_code;
  codeword_t              mem_rdata;  // raw codeword from the array
  logic [`SPM_DATA_W-1:0] dec_data;
  logic                   dec_corr;
  logic                   dec_uncorr;
  logic                   log;
  logic                   log_uncorr;
  logic [`SPM_ADDR_W-1:0] log_addr;

  spm_ctrl i_spm_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .we_i           (we_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .inject_s_i     (inject_s_i),
    .inject_d_i     (inject_d_i),
    .dec_data_i     (dec_data),
    .dec_corr_i     (dec_corr),
    .dec_uncorr_i   (dec_uncorr),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_inject_s_o (mem_inject_s),
    .mem_inject_d_o (mem_inject_d),
    .enc_data_o     (enc_data),
    .ack_o          (ack_o),
    .rdata_o        (rdata_o),
    .err_corr_o     (err_corr_o),
    .err_uncorr_o   (err_uncorr_o),
    .log_o          (log),
    .log_uncorr_o   (log_uncorr),
    .log_addr_o     (log_addr)
  );

  ecc_encode i_ecc_encode (
    .data_i (enc_data),
    .code_o (enc_code)
  );

  sp_sram #(
    .DataWidth (`SPM_CODE_W),
    .NumWords  (`SPM_WORDS),
    .OutRegs   (`SPM_OUT_REGS)
  ) i_sp_sram (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .req_i               (mem_req),
    .we_i                (mem_we),
    .addr_i              (mem_addr),
    .wdata_i             (enc_code),
    .inject_s_biterror_i (mem_inject_s),
    .inject_d_biterror_i (mem_inject_d),
    .rdata_o             (mem_rdata)
  );

  ecc_decode i_ecc_decode (
    .code_i   (mem_rdata),
    .data_o   (dec_data),
    .corr_o   (dec_corr),
    .uncorr_o (dec_uncorr)
  );

  err_log i_err_log (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .log_i           (log),
    .uncorr_i        (log_uncorr),
    .addr_i          (log_addr),
    .corr_count_o    (corr_count_o),
    .last_err_addr_o (last_err_addr_o)
  );

endmodule

// File: src/spm_ctrl.sv
`include "spm_cfg.svh"

module spm_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // requester side
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`SPM_ADDR_W-1:0] addr_i,
  input  logic [`SPM_DATA_W-1:0] wdata_i,
  input  logic [`SPM_BE_W-1:0]   be_i,
  input  logic                   inject_s_i,
  input  logic                   inject_d_i,
  // decoder results
  input  logic [`SPM_DATA_W-1:0] dec_data_i,
  input  logic                   dec_corr_i,
  input  logic                   dec_uncorr_i,
  // sram strobes
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`SPM_ADDR_W-1:0] mem_addr_o,
  output logic                   mem_inject_s_o,
  output logic                   mem_inject_d_o,
  output logic [`SPM_DATA_W-1:0] enc_data_o,
  // response
  output logic                   ack_o,
  output logic [`SPM_DATA_W-1:0] rdata_o,
  output logic                   err_corr_o,
  output logic                   err_uncorr_o,
  // logger
  output logic                   log_o,
  output logic                   log_uncorr_o,
  output logic [`SPM_ADDR_W-1:0] log_addr_o
);

  localparam logic [2:0] st_idle        = 3'd0;
  localparam logic [2:0] st_issue       = 3'd1; // sram strobe out
  localparam logic [2:0] st_read_wait   = 3'd2; // waiting on read latency
  localparam logic [2:0] st_merge_write = 3'd3; // rmw write back
  localparam logic [2:0] st_respond     = 3'd4; // ack cycle

  logic [2:0]             state_q;
  logic [1:0]             wait_cnt_q;
  logic                   wait_done;
  logic                   we_q;
  logic                   inj_s_q;
  logic                   inj_d_q;
  logic                   corr_q;
  logic                   uncorr_q;
  logic                   accept;
  logic                   full_wr;
  logic [`SPM_ADDR_W-1:0] addr_q;
  logic [`SPM_DATA_W-1:0] wdata_q;     // request data, later the merged word
  logic [`SPM_BE_W-1:0]   be_q;
  logic [`SPM_DATA_W-1:0] rdata_q;
  logic [`SPM_DATA_W-1:0] merge_data;

  assign accept    = req_i && ((state_q == st_idle) || (state_q == st_respond));
  assign full_wr   = we_q && (&be_q);                      // no read needed
  assign wait_done = (wait_cnt_q == 2'(`SPM_OUT_REGS));    // codeword valid now

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      wait_cnt_q <= '0;
      we_q       <= 1'b0;
      inj_s_q    <= 1'b0;
      inj_d_q    <= 1'b0;
      corr_q     <= 1'b0;
      uncorr_q   <= 1'b0;
    end else begin
      case (state_q)
        st_idle, st_respond: begin
          if (req_i) begin
            state_q  <= st_issue;
            we_q     <= we_i;
            inj_s_q  <= we_i & inject_s_i; // reads ignore injection
            inj_d_q  <= we_i & inject_d_i;
            corr_q   <= 1'b0;
            uncorr_q <= 1'b0;
          end else begin
            state_q <= st_idle;
          end
        end
        st_issue: begin
          wait_cnt_q <= '0;
          state_q    <= full_wr ? st_respond : st_read_wait;
        end
        st_read_wait: begin
          if (wait_done) begin
            corr_q   <= dec_corr_i;
            uncorr_q <= dec_uncorr_i;
            // bad old word aborts the partial write
            if (we_q && !dec_uncorr_i) begin
              state_q <= st_merge_write;
            end else begin
              state_q <= st_respond;
            end
          end else begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
          end
        end
        st_merge_write: state_q <= st_respond;
        default:        state_q <= st_idle;
      endcase
    end
  end

  // payload, no reset
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end else if ((state_q == st_read_wait) && wait_done) begin
      rdata_q <= dec_data_i;
      wdata_q <= merge_data; // only written back for a partial write
    end
  end

  // enabled bytes from the request over corrected old data
  always_comb begin
    for (int b = 0; b < `SPM_BE_W; b++) begin
      merge_data[8*b +: 8] = be_q[b] ? wdata_q[8*b +: 8] : dec_data_i[8*b +: 8];
    end
  end

  assign mem_req_o      = (state_q == st_issue) || (state_q == st_merge_write);
  assign mem_we_o       = ((state_q == st_issue) && full_wr) || (state_q == st_merge_write);
  assign mem_addr_o     = addr_q;
  assign mem_inject_s_o = inj_s_q & mem_we_o;
  assign mem_inject_d_o = inj_d_q & mem_we_o;
  assign enc_data_o     = wdata_q;

  assign ack_o        = (state_q == st_respond);
  assign rdata_o      = rdata_q;
  assign err_corr_o   = ack_o & corr_q;   // flags only mean something with ack
  assign err_uncorr_o = ack_o & uncorr_q;

  // logger samples at the end of the ack cycle
  assign log_o        = ack_o & (corr_q | uncorr_q);
  assign log_uncorr_o = uncorr_q;
  assign log_addr_o   = addr_q;

  // one request in flight, next one no earlier than the ack
  a_no_req_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |-> ((state_q == st_idle) || (state_q == st_respond)))
    else $error("spm_ctrl: req_i while request outstanding");

  a_ack_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o |=> !ack_o)
    else $error("spm_ctrl: ack_o held longer than one cycle");

endmodule

// File: src/err_log.sv
`include "spm_cfg.svh"

module err_log (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   log_i,       // one cycle event strobe
  input  logic                   uncorr_i,    // event kind, 1 = double error
  input  logic [`SPM_ADDR_W-1:0] addr_i,
  output logic [`SPM_CNT_W-1:0]  corr_count_o,
  output logic [`SPM_ADDR_W-1:0] last_err_addr_o
);

  logic [`SPM_CNT_W-1:0]  count_q;
  logic [`SPM_ADDR_W-1:0] last_addr_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q     <= '0;
      last_addr_q <= '0;
    end else if (log_i) begin
      last_addr_q <= addr_i; // any kind of event
      // only corrected events count, stick at all ones
      if (!uncorr_i && (count_q != '1)) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign corr_count_o    = count_q;
  assign last_err_addr_o = last_addr_q;

endmodule

// File: src/ecc_decode.sv
`include "spm_cfg.svh"

module ecc_decode import spm_pkg::*; (
  input  codeword_t              code_i,
  output logic [`SPM_DATA_W-1:0] data_o,
  output logic                   corr_o,
  output logic                   uncorr_o
);

  codeword_t             fix;    // raw view, repaired in place
  codeword_t             fields; // same word back in fields order
  logic [`SPM_CHK_W-1:0] syn;
  logic                  odd;    // overall parity broken

  always_comb begin
    fix      = code_i;
    syn      = syndrome(code_i.raw);
    odd      = ^code_i.raw;
    corr_o   = 1'b0;
    uncorr_o = 1'b0;

    if (odd) begin
      // single error, syndrome names the bit
      // zero syndrome points at raw[0], the parity bit itself
      if (syn < `SPM_CODE_W) begin
        fix.raw[syn] = ~code_i.raw[syn];
        corr_o       = 1'b1;
      end else begin
        uncorr_o = 1'b1; // position past the word, more than one flip
      end
    end else if (syn != '0) begin
      uncorr_o = 1'b1;   // even parity, nonzero syndrome, double error
    end

    fields = raw_to_fields(fix.raw);
    data_o = fields.fields.data;
  end

endmodule

// File: src/ecc_encode.sv
`include "spm_cfg.svh"

module ecc_encode import spm_pkg::*; (
  input  logic [`SPM_DATA_W-1:0] data_i,
  output codeword_t              code_o
);

  codeword_t             cw;   // fields order
  logic [`SPM_CHK_W-1:0] syn;  // syndrome with zero check bits

  always_comb begin
    // data in place, check and parity cleared
    cw.fields.parity = 1'b0;
    cw.fields.check  = '0;
    cw.fields.data   = data_i;

    // each check bit sits at 2**i, so it cancels syndrome bit i
    syn = syndrome(fields_to_raw(cw));
    cw.fields.check = syn;

    // overall parity makes the whole word even
    cw.fields.parity = ^{cw.fields.check, cw.fields.data};

    code_o.raw = fields_to_raw(cw); // stored in hamming order
  end

endmodule

// File: src/sp_sram.sv
`include "spm_cfg.svh"

module sp_sram import spm_pkg::*; #(
  parameter int unsigned DataWidth = 39,   // codeword bits per entry
  parameter int unsigned NumWords  = 256,
  parameter bit          OutRegs   = 0     // extra output stage, read lat = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  codeword_t                   wdata_i,
  input  logic                        inject_s_biterror_i,
  input  logic                        inject_d_biterror_i,
  output codeword_t                   rdata_o
);

  logic [DataWidth-1:0] mem_q [NumWords]; // no reset on the array
  codeword_t            wr_word;
  codeword_t            rd_q;             // first read stage

  // fault injection on the way in
  always_comb begin
    wr_word        = wdata_i;
    wr_word.raw[0] = wdata_i.raw[0] ^ (inject_s_biterror_i | inject_d_biterror_i);
    wr_word.raw[1] = wdata_i.raw[1] ^ inject_d_biterror_i; // second flip, double error
  end

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wr_word.raw;
    end
  end

  // read first, old contents come out even on a write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_q <= '0;
    end else if (req_i) begin
      rd_q.raw <= mem_q[addr_i];
    end
  end

  if (OutRegs) begin : g_out_reg
    codeword_t rd2_q; // free running, keeps back to back reads in flight

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rd2_q <= '0;
      end else begin
        rd2_q <= rd_q;
      end
    end

    assign rdata_o = rd2_q;
  end else begin : g_no_out_reg
    assign rdata_o = rd_q;
  end

  // out of range access would alias
  a_addr_range: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |-> (addr_i < NumWords))
    else $error("sp_sram: address %0d beyond %0d words", addr_i, NumWords);

endmodule

// File: src/spm_pkg.sv
`include "spm_cfg.svh"

package spm_pkg;

  // one stored word, seen as named fields or as hamming positions
  // raw[0] is overall parity, raw[2**i] holds check[i], data fills the rest
  typedef union packed {
    struct packed {
      logic                   parity; // even parity over all 39 bits
      logic [`SPM_CHK_W-1:0]  check;
      logic [`SPM_DATA_W-1:0] data;
    } fields;
    logic [`SPM_CODE_W-1:0] raw;
  } codeword_t;

  // scatter fields into hamming position order
  function automatic logic [`SPM_CODE_W-1:0] fields_to_raw(input codeword_t cw);
    logic [`SPM_CODE_W-1:0] r;
    int unsigned            c;
    int unsigned            d;
    r    = '0;
    c    = 0;
    d    = 0;
    r[0] = cw.fields.parity;
    for (int k = 1; k < `SPM_CODE_W; k++) begin
      if ((k & (k - 1)) == 0) begin // power of two slot
        r[k] = cw.fields.check[c];
        c++;
      end else begin
        r[k] = cw.fields.data[d];
        d++;
      end
    end
    return r;
  endfunction

  // inverse of the scatter above
  function automatic codeword_t raw_to_fields(input logic [`SPM_CODE_W-1:0] r);
    codeword_t   cw;
    int unsigned c;
    int unsigned d;
    cw.raw           = '0;
    c                = 0;
    d                = 0;
    cw.fields.parity = r[0];
    for (int k = 1; k < `SPM_CODE_W; k++) begin
      if ((k & (k - 1)) == 0) begin
        cw.fields.check[c] = r[k];
        c++;
      end else begin
        cw.fields.data[d] = r[k];
        d++;
      end
    end
    return cw;
  endfunction

  // xor of the positions of all set bits, zero for a clean word
  function automatic logic [`SPM_CHK_W-1:0] syndrome(input logic [`SPM_CODE_W-1:0] r);
    logic [`SPM_CHK_W-1:0] s;
    s = '0;
    for (int k = 1; k < `SPM_CODE_W; k++) begin
      if (r[k]) begin
        s = s ^ `SPM_CHK_W'(k);
      end
    end
    return s;
  endfunction

endpackage

// File: include/spm_cfg.svh
`ifndef SPM_CFG_SVH
`define SPM_CFG_SVH

// scratchpad geometry
`define SPM_DATA_W   32                     // user data word
`define SPM_WORDS    256                    // words in the array
`define SPM_ADDR_W   ($clog2(`SPM_WORDS))   // word address
`define SPM_BE_W     4                      // one enable per byte

// read pipeline, latency is this plus one
`define SPM_OUT_REGS 0

// secded codeword layout
`define SPM_CHK_W    6                      // hamming check bits
`define SPM_CODE_W   39                     // data + check + overall parity

// error log counter width
`define SPM_CNT_W    16

`endif
